/* design/noc_pkg.sv */
/*
 * NoC shared definitions
 * Node count, bus widths, the per-node register map and the AXI response
 * codes used by every block of the network
 */
package noc_pkg;

  localparam int NOC_SIZE = 4;

  typedef logic [1:0]  node_id_t;
  typedef logic [7:0]  axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [1:0]  aresp_t;

  // Fill count of a receive FIFO, wide enough for a depth of 4
  typedef logic [2:0]  fifo_cnt_t;

  // AXI response codes
  localparam aresp_t RESP_OKAY   = 2'b00;
  localparam aresp_t RESP_SLVERR = 2'b10;

  // Register map of one node
  // Tx window 0x00-0x0C, bits [3:2] select the destination node
  localparam axi_addr_t ADDR_TX_BASE   = 8'h00;
  // Pops the head payload
  localparam axi_addr_t ADDR_RX_DATA   = 8'h10;
  // Head source id in [1:0], fill count in [10:8]
  localparam axi_addr_t ADDR_RX_STATUS = 8'h14;

  localparam int RX_FIFO_DEPTH_DEFAULT = 4;

endpackage

/* design/flit_if.sv */
/*
 * Flit interface
 * One-flit packet transfer with a valid/ready handshake
 */
`timescale 1ns/1ps

interface flit_if import noc_pkg::*; ();

  logic      valid;
  logic      ready;
  node_id_t  src;
  node_id_t  dest;
  axi_data_t data;

  modport sender (output valid, src, dest, data, input ready);

  modport receiver (input valid, src, dest, data, output ready);

endinterface

/* design/axi_lite_ni.sv */
/*
 * AXI4-Lite network interface
 * Packs a write into a one-flit packet for the crossbar and answers reads
 * of the receive FIFO with its payload or its status word
 */
`timescale 1ns/1ps

module axi_lite_ni import noc_pkg::*; #(
  parameter node_id_t NODE_ID = '0
) (
  input  logic      clk_noc,
  input  logic      reset,
  input  axi_addr_t awaddr,
  input  logic      awvalid,
  output logic      awready,
  input  axi_data_t wdata,
  input  axi_strb_t wstrb,
  input  logic      wvalid,
  output logic      wready,
  output aresp_t    bresp,
  output logic      bvalid,
  input  logic      bready,
  input  axi_addr_t araddr,
  input  logic      arvalid,
  output logic      arready,
  output axi_data_t rdata,
  output aresp_t    rresp,
  output logic      rvalid,
  input  logic      rready,
  flit_if.sender    tx,
  flit_if.receiver  rx,
  input  fifo_cnt_t rx_count
);

  typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_t;

  wr_state_t wr_state;
  logic      aw_held;
  logic      w_held;
  axi_addr_t addr_q;
  axi_data_t data_q;
  axi_strb_t strb_q;
  logic      tx_ok;
  logic      rd_pend;
  logic      ar_fire;
  axi_data_t status_word;

  assign awready = !aw_held;
  assign wready  = !w_held;

  // Aligned address inside the tx window and a full-word strobe
  assign tx_ok = (addr_q[7:4] == ADDR_TX_BASE[7:4]) && (addr_q[1:0] == 2'b00) &&
                 (strb_q == '1);

  always_ff @(posedge clk_noc) begin
    if (reset) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      wr_state <= WR_IDLE;
    end else begin
      if (awvalid && awready) aw_held <= 1'b1;
      if (wvalid && wready) w_held <= 1'b1;
      case (wr_state)
        WR_IDLE: if (aw_held && w_held) wr_state <= tx_ok ? WR_SEND : WR_RESP;
        WR_SEND: if (tx.ready) wr_state <= WR_RESP;
        WR_RESP: begin
          // Both channels reopen only after the B handshake
          if (bready) begin
            wr_state <= WR_IDLE;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_noc) begin
    if (awvalid && awready) addr_q <= awaddr;
    if (wvalid && wready) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
    if (wr_state == WR_IDLE && aw_held && w_held) bresp <= tx_ok ? RESP_OKAY : RESP_SLVERR;
  end

  assign tx.valid = (wr_state == WR_SEND);
  assign tx.src   = NODE_ID;
  assign tx.dest  = addr_q[3:2];
  assign tx.data  = data_q;
  assign bvalid   = (wr_state == WR_RESP);

  // Read side
  assign arready  = !rd_pend;
  assign ar_fire  = arvalid && arready;
  assign rvalid   = rd_pend;
  assign rx.ready = ar_fire && (araddr == ADDR_RX_DATA) && rx.valid;

  assign status_word = {21'b0, rx_count, 6'b0, (rx.valid ? rx.src : 2'b00)};

  always_ff @(posedge clk_noc) begin
    if (reset) begin
      rd_pend <= 1'b0;
    end else if (ar_fire) begin
      rd_pend <= 1'b1;
    end else if (rready) begin
      rd_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk_noc) begin
    if (ar_fire) begin
      case (araddr)
        ADDR_RX_DATA: begin
          rdata <= rx.valid ? rx.data : '0;
          rresp <= rx.valid ? RESP_OKAY : RESP_SLVERR;
        end
        ADDR_RX_STATUS: begin
          rdata <= status_word;
          rresp <= RESP_OKAY;
        end
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

/* design/noc_arbiter.sv */
/*
 * Crossbar arbiter
 * Round-robin grant of inputs to outputs with one pointer per output
 */
`timescale 1ns/1ps

module noc_arbiter import noc_pkg::*; (
  input  logic                               clk_noc,
  input  logic                               reset,
  input  logic [NOC_SIZE-1:0][NOC_SIZE-1:0]  req,
  input  logic [NOC_SIZE-1:0]                out_ready,
  output logic [NOC_SIZE-1:0][NOC_SIZE-1:0]  grant
);

  node_id_t ptr    [NOC_SIZE];
  node_id_t winner [NOC_SIZE];

  // First requester at or after the pointer wins
  always_comb begin
    int   idx;
    logic found;
    for (int o = 0; o < NOC_SIZE; o++) begin
      grant[o]  = '0;
      winner[o] = ptr[o];
      found     = 1'b0;
      for (int k = 0; k < NOC_SIZE; k++) begin
        idx = (int'(ptr[o]) + k) % NOC_SIZE;
        if (!found && req[o][idx]) begin
          found          = 1'b1;
          winner[o]      = node_id_t'(idx);
          grant[o][idx]  = 1'b1;
        end
      end
    end
  end

  // Pointer moves past the winner only on a completed transfer
  always_ff @(posedge clk_noc) begin
    if (reset) begin
      for (int o = 0; o < NOC_SIZE; o++) ptr[o] <= '0;
    end else begin
      for (int o = 0; o < NOC_SIZE; o++) begin
        if (|grant[o] && out_ready[o]) begin
          ptr[o] <= node_id_t'((int'(winner[o]) + 1) % NOC_SIZE);
        end
      end
    end
  end

endmodule

/* design/noc_crossbar.sv */
/*
 * Crossbar datapath
 * Turns flit destinations into requests and steers granted flits to outputs
 */
`timescale 1ns/1ps

module noc_crossbar import noc_pkg::*; (
  flit_if.receiver                           in  [NOC_SIZE],
  flit_if.sender                             out [NOC_SIZE],
  output logic [NOC_SIZE-1:0][NOC_SIZE-1:0]  req,
  output logic [NOC_SIZE-1:0]                out_ready,
  input  logic [NOC_SIZE-1:0][NOC_SIZE-1:0]  grant
);

  logic      in_valid [NOC_SIZE];
  node_id_t  in_src   [NOC_SIZE];
  node_id_t  in_dest  [NOC_SIZE];
  axi_data_t in_data  [NOC_SIZE];

  for (genvar i = 0; i < NOC_SIZE; i++) begin : g_in
    assign in_valid[i] = in[i].valid;
    assign in_src[i]   = in[i].src;
    assign in_dest[i]  = in[i].dest;
    assign in_data[i]  = in[i].data;
    // Only the granted input sees its output's ready
    assign in[i].ready = grant[in_dest[i]][i] && out_ready[in_dest[i]];
  end

  for (genvar o = 0; o < NOC_SIZE; o++) begin : g_out
    node_id_t  sel_src;
    axi_data_t sel_data;

    for (genvar i = 0; i < NOC_SIZE; i++) begin : g_req
      assign req[o][i] = in_valid[i] && (in_dest[i] == node_id_t'(o));
    end

    // Grant is one-hot, so an OR of the masked inputs is the mux
    always_comb begin
      sel_src  = '0;
      sel_data = '0;
      for (int i = 0; i < NOC_SIZE; i++) begin
        if (grant[o][i]) begin
          sel_src  = sel_src | in_src[i];
          sel_data = sel_data | in_data[i];
        end
      end
    end

    assign out[o].valid = |grant[o];
    assign out[o].src   = sel_src;
    assign out[o].dest  = node_id_t'(o);
    assign out[o].data  = sel_data;
    assign out_ready[o] = out[o].ready;
  end

endmodule

/* design/rx_fifo.sv */
/*
 * Receive FIFO
 * Circular buffer of arriving flits for one node
 */
`timescale 1ns/1ps

module rx_fifo import noc_pkg::*; #(
  parameter int DEPTH = RX_FIFO_DEPTH_DEFAULT
) (
  input  logic      clk_noc,
  input  logic      reset,
  flit_if.receiver  wr,
  flit_if.sender    rd,
  output fifo_cnt_t count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  node_id_t         mem_src  [DEPTH];
  axi_data_t        mem_data [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push;
  logic             pop;

  assign wr.ready = (count != fifo_cnt_t'(DEPTH));
  assign rd.valid = (count != '0);
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  assign rd.src  = mem_src[rd_ptr];
  assign rd.data = mem_data[rd_ptr];
  // Every entry here went to the same crossbar output
  assign rd.dest = wr.dest;

  always_ff @(posedge clk_noc) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_noc) begin
    if (push) begin
      mem_src[wr_ptr]  <= wr.src;
      mem_data[wr_ptr] <= wr.data;
    end
  end

endmodule

/* design/ravenoc_lite.sv */
/*
 * RaveNoC lite top level
 * Four AXI4-Lite nodes joined by a round-robin crossbar with per-node
 * receive FIFOs
 */
`timescale 1ns/1ps

module ravenoc_lite import noc_pkg::*; (
  input  logic      clk_noc,
  input  logic      reset,
  // Write address and data
  input  axi_addr_t awaddr  [NOC_SIZE-1:0],
  input  logic      awvalid [NOC_SIZE-1:0],
  output logic      awready [NOC_SIZE-1:0],
  input  axi_data_t wdata   [NOC_SIZE-1:0],
  input  axi_strb_t wstrb   [NOC_SIZE-1:0],
  input  logic      wvalid  [NOC_SIZE-1:0],
  output logic      wready  [NOC_SIZE-1:0],
  // Write response
  output aresp_t    bresp   [NOC_SIZE-1:0],
  output logic      bvalid  [NOC_SIZE-1:0],
  input  logic      bready  [NOC_SIZE-1:0],
  // Read address and data
  input  axi_addr_t araddr  [NOC_SIZE-1:0],
  input  logic      arvalid [NOC_SIZE-1:0],
  output logic      arready [NOC_SIZE-1:0],
  output axi_data_t rdata   [NOC_SIZE-1:0],
  output aresp_t    rresp   [NOC_SIZE-1:0],
  output logic      rvalid  [NOC_SIZE-1:0],
  input  logic      rready  [NOC_SIZE-1:0]
);

  logic [NOC_SIZE-1:0][NOC_SIZE-1:0] req;
  logic [NOC_SIZE-1:0][NOC_SIZE-1:0] grant;
  logic [NOC_SIZE-1:0]               out_ready;
  fifo_cnt_t                         rx_count [NOC_SIZE];

  flit_if tx_if  [NOC_SIZE] ();
  flit_if out_if [NOC_SIZE] ();
  flit_if rx_if  [NOC_SIZE] ();

  for (genvar i = 0; i < NOC_SIZE; i++) begin : g_node
    axi_lite_ni #(
      .NODE_ID (node_id_t'(i))
    ) u_ni (
      .clk_noc  (clk_noc),
      .reset    (reset),
      .awaddr   (awaddr[i]),
      .awvalid  (awvalid[i]),
      .awready  (awready[i]),
      .wdata    (wdata[i]),
      .wstrb    (wstrb[i]),
      .wvalid   (wvalid[i]),
      .wready   (wready[i]),
      .bresp    (bresp[i]),
      .bvalid   (bvalid[i]),
      .bready   (bready[i]),
      .araddr   (araddr[i]),
      .arvalid  (arvalid[i]),
      .arready  (arready[i]),
      .rdata    (rdata[i]),
      .rresp    (rresp[i]),
      .rvalid   (rvalid[i]),
      .rready   (rready[i]),
      .tx       (tx_if[i]),
      .rx       (rx_if[i]),
      .rx_count (rx_count[i])
    );

    rx_fifo #(
      .DEPTH (RX_FIFO_DEPTH_DEFAULT)
    ) u_rx_fifo (
      .clk_noc (clk_noc),
      .reset   (reset),
      .wr      (out_if[i]),
      .rd      (rx_if[i]),
      .count   (rx_count[i])
    );
  end

  noc_crossbar u_crossbar (
    .in        (tx_if),
    .out       (out_if),
    .req       (req),
    .out_ready (out_ready),
    .grant     (grant)
  );

  noc_arbiter u_arbiter (
    .clk_noc   (clk_noc),
    .reset     (reset),
    .req       (req),
    .out_ready (out_ready),
    .grant     (grant)
  );

endmodule

/* test/noc_checker.sv */
/*
 * NoC response checker
 * Watches every AXI4-Lite handshake at the top level, keeps a model of the
 * words in flight per source and destination and compares each response
 */
`timescale 1ns/1ps

module noc_checker import noc_pkg::*; (
  input  logic      clk_noc,
  input  logic      reset,
  input  axi_addr_t awaddr  [NOC_SIZE-1:0],
  input  logic      awvalid [NOC_SIZE-1:0],
  input  logic      awready [NOC_SIZE-1:0],
  input  axi_data_t wdata   [NOC_SIZE-1:0],
  input  axi_strb_t wstrb   [NOC_SIZE-1:0],
  input  logic      wvalid  [NOC_SIZE-1:0],
  input  logic      wready  [NOC_SIZE-1:0],
  input  aresp_t    bresp   [NOC_SIZE-1:0],
  input  logic      bvalid  [NOC_SIZE-1:0],
  input  logic      bready  [NOC_SIZE-1:0],
  input  axi_addr_t araddr  [NOC_SIZE-1:0],
  input  logic      arvalid [NOC_SIZE-1:0],
  input  logic      arready [NOC_SIZE-1:0],
  input  axi_data_t rdata   [NOC_SIZE-1:0],
  input  aresp_t    rresp   [NOC_SIZE-1:0],
  input  logic      rvalid  [NOC_SIZE-1:0],
  input  logic      rready  [NOC_SIZE-1:0],
  output int        errors,
  output int        pending
);

  // Expected words in one circular buffer per source and destination pair
  axi_data_t exp_mem [NOC_SIZE*NOC_SIZE][256];
  int        q_wr    [NOC_SIZE*NOC_SIZE];
  int        q_rd    [NOC_SIZE*NOC_SIZE];
  int        model_cnt [NOC_SIZE];

  axi_addr_t aw_addr   [NOC_SIZE];
  axi_data_t w_data    [NOC_SIZE];
  axi_strb_t w_strb    [NOC_SIZE];
  logic      aw_seen   [NOC_SIZE];
  logic      w_seen    [NOC_SIZE];
  logic      r_pend    [NOC_SIZE];
  logic      r_status  [NOC_SIZE];
  axi_data_t exp_rdata [NOC_SIZE];
  aresp_t    exp_rresp [NOC_SIZE];
  int        exp_cnt   [NOC_SIZE];
  node_id_t  head_src  [NOC_SIZE];

  logic      prev_bv    [NOC_SIZE];
  logic      prev_br    [NOC_SIZE];
  aresp_t    prev_bresp [NOC_SIZE];
  logic      prev_rv    [NOC_SIZE];
  logic      prev_rr    [NOC_SIZE];
  aresp_t    prev_rresp [NOC_SIZE];
  axi_data_t prev_rdata [NOC_SIZE];

  task automatic report_mismatch(input int n, input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH node %0d %s: got %h expected %h", n, sig, got, exp);
    errors++;
  endtask

  task automatic report_failure(input int n, input string msg);
    $display("ERROR node %0d: %s", n, msg);
    errors++;
  endtask

  always @(posedge clk_noc) begin
    logic   ok;
    aresp_t exp_b;
    int     dst;
    int     p;
    if (reset) begin
      errors  = 0;
      pending = 0;
      for (int i = 0; i < NOC_SIZE*NOC_SIZE; i++) begin
        q_wr[i] = 0;
        q_rd[i] = 0;
      end
      for (int n = 0; n < NOC_SIZE; n++) begin
        model_cnt[n] = 0;
        aw_seen[n]   = 1'b0;
        w_seen[n]    = 1'b0;
        r_pend[n]    = 1'b0;
        head_src[n]  = '0;
        prev_bv[n]   = 1'b0;
        prev_br[n]   = 1'b0;
        prev_rv[n]   = 1'b0;
        prev_rr[n]   = 1'b0;
      end
    end else begin
      // Write side first so that a word is counted before any read in this cycle
      for (int n = 0; n < NOC_SIZE; n++) begin
        if (awvalid[n] && awready[n]) begin
          aw_addr[n] = awaddr[n];
          aw_seen[n] = 1'b1;
        end
        if (wvalid[n] && wready[n]) begin
          w_data[n] = wdata[n];
          w_strb[n] = wstrb[n];
          w_seen[n] = 1'b1;
        end
        if (prev_bv[n] && !prev_br[n] && (!bvalid[n] || bresp[n] !== prev_bresp[n]))
          report_failure(n, "write response changed while stalled");
        if (bvalid[n] && !prev_bv[n]) begin
          if (!(aw_seen[n] && w_seen[n])) begin
            report_failure(n, "write response without a write request");
          end else begin
            // Only the four tx addresses with a full strobe send a flit
            ok = (aw_addr[n] == 8'h00) || (aw_addr[n] == 8'h04) ||
                 (aw_addr[n] == 8'h08) || (aw_addr[n] == 8'h0c);
            ok = ok && (w_strb[n] == 4'hf);
            exp_b = ok ? RESP_OKAY : RESP_SLVERR;
            if (bresp[n] !== exp_b) report_mismatch(n, "bresp", bresp[n], exp_b);
            // The flit sits in the destination FIFO once bvalid rises
            if (ok) begin
              dst = aw_addr[n][3:2];
              p   = n * NOC_SIZE + dst;
              exp_mem[p][q_wr[p] % 256] = w_data[n];
              q_wr[p]++;
              model_cnt[dst]++;
              pending++;
            end
          end
        end
        if (bvalid[n] && bready[n]) begin
          aw_seen[n] = 1'b0;
          w_seen[n]  = 1'b0;
        end
      end

      for (int n = 0; n < NOC_SIZE; n++) begin
        if (prev_rv[n] && !prev_rr[n] &&
            (!rvalid[n] || rdata[n] !== prev_rdata[n] || rresp[n] !== prev_rresp[n]))
          report_failure(n, "read response changed while stalled");
        if (rvalid[n] && !r_pend[n]) report_failure(n, "read response without a read request");
        if (rvalid[n] && rready[n] && r_pend[n]) begin
          if (rresp[n] !== exp_rresp[n]) report_mismatch(n, "rresp", rresp[n], exp_rresp[n]);
          if (r_status[n] && exp_cnt[n] == 0) begin
            if (rdata[n] !== 32'h0) report_mismatch(n, "rdata status", rdata[n], 32'h0);
          end else if (r_status[n]) begin
            if ((rdata[n] & 32'hffff_fffc) !== (exp_cnt[n] << 8))
              report_mismatch(n, "rdata status", rdata[n] & 32'hffff_fffc, exp_cnt[n] << 8);
            head_src[n] = rdata[n][1:0];
          end else if (rdata[n] !== exp_rdata[n]) begin
            report_mismatch(n, "rdata", rdata[n], exp_rdata[n]);
          end
          r_pend[n] = 1'b0;
        end
        if (arvalid[n] && arready[n]) begin
          r_pend[n]    = 1'b1;
          r_status[n]  = (araddr[n] == ADDR_RX_STATUS);
          exp_rdata[n] = '0;
          exp_rresp[n] = RESP_OKAY;
          exp_cnt[n]   = model_cnt[n];
          if (araddr[n] == ADDR_RX_DATA) begin
            p = int'(head_src[n]) * NOC_SIZE + n;
            if (model_cnt[n] == 0) begin
              exp_rresp[n] = RESP_SLVERR;
            end else if (q_rd[p] == q_wr[p]) begin
              report_failure(n, "data read with no word queued from the reported source");
            end else begin
              exp_rdata[n] = exp_mem[p][q_rd[p] % 256];
              q_rd[p]++;
              model_cnt[n]--;
              pending--;
            end
          end else if (araddr[n] != ADDR_RX_STATUS) begin
            exp_rresp[n] = RESP_SLVERR;
          end
        end
        prev_bv[n]    = bvalid[n];
        prev_br[n]    = bready[n];
        prev_bresp[n] = bresp[n];
        prev_rv[n]    = rvalid[n];
        prev_rr[n]    = rready[n];
        prev_rresp[n] = rresp[n];
        prev_rdata[n] = rdata[n];
      end
    end
  end

endmodule

/* test/tb_ravenoc_lite.sv */
/*
 * RaveNoC lite testbench
 * Random AXI4-Lite traffic on all four nodes, error cases, back-pressure
 * and stalled contention, checked by noc_checker
 */
`timescale 1ns/1ps

module tb_ravenoc_lite import noc_pkg::*; ();

  localparam int P2P_WORDS = 8;
  localparam int BP_WORDS  = RX_FIFO_DEPTH_DEFAULT + 2;
  localparam int SAT_WORDS = 8;
  // Writes plus status and data reads per word, and the fixed reads
  localparam int TOTAL_TXN = NOC_SIZE * (6 + 3 * (P2P_WORDS + BP_WORDS + SAT_WORDS));

  logic      clk_noc;
  logic      reset;
  axi_addr_t awaddr  [NOC_SIZE-1:0];
  logic      awvalid [NOC_SIZE-1:0];
  logic      awready [NOC_SIZE-1:0];
  axi_data_t wdata   [NOC_SIZE-1:0];
  axi_strb_t wstrb   [NOC_SIZE-1:0];
  logic      wvalid  [NOC_SIZE-1:0];
  logic      wready  [NOC_SIZE-1:0];
  aresp_t    bresp   [NOC_SIZE-1:0];
  logic      bvalid  [NOC_SIZE-1:0];
  logic      bready  [NOC_SIZE-1:0];
  axi_addr_t araddr  [NOC_SIZE-1:0];
  logic      arvalid [NOC_SIZE-1:0];
  logic      arready [NOC_SIZE-1:0];
  axi_data_t rdata   [NOC_SIZE-1:0];
  aresp_t    rresp   [NOC_SIZE-1:0];
  logic      rvalid  [NOC_SIZE-1:0];
  logic      rready  [NOC_SIZE-1:0];

  int        chk_errors;
  int        chk_pending;
  integer    seed = 32'h906f;
  bit        stall;
  int        b_done;
  int        tb_errors;
  int        err_base;
  int        tests_passed;
  int        tests_failed;
  node_id_t  dest_tbl [NOC_SIZE][16];
  axi_data_t data_tbl [NOC_SIZE][16];

  ravenoc_lite UUT (.*);

  noc_checker u_checker (
    .*,
    .errors  (chk_errors),
    .pending (chk_pending)
  );

  initial begin
    clk_noc = 1'b0;
    forever #2 clk_noc = ~clk_noc;
  end

  initial begin
    repeat (TOTAL_TXN * 64) @(posedge clk_noc);
    $display("Timeout: traffic did not complete within %0d cycles", TOTAL_TXN * 64);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic ready_draw();
    if (!stall) return 1'b1;
    return ($random(seed) % 3) != 0;
  endfunction

  task automatic axi_write(input int n, input axi_addr_t a, input axi_data_t d,
                           input axi_strb_t s);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    awaddr[n]  <= a;
    awvalid[n] <= 1'b1;
    wdata[n]   <= d;
    wstrb[n]   <= s;
    wvalid[n]  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clk_noc);
      if (!aw_done && awready[n]) begin
        aw_done = 1'b1;
        awvalid[n] <= 1'b0;
      end
      if (!w_done && wready[n]) begin
        w_done = 1'b1;
        wvalid[n] <= 1'b0;
      end
    end
    bready[n] <= ready_draw();
    @(posedge clk_noc);
    while (!(bvalid[n] && bready[n])) begin
      bready[n] <= ready_draw();
      @(posedge clk_noc);
    end
    bready[n] <= 1'b0;
    b_done++;
  endtask

  task automatic axi_read(input int n, input axi_addr_t a, output axi_data_t d);
    araddr[n]  <= a;
    arvalid[n] <= 1'b1;
    @(posedge clk_noc);
    while (!arready[n]) @(posedge clk_noc);
    arvalid[n] <= 1'b0;
    rready[n]  <= ready_draw();
    @(posedge clk_noc);
    while (!(rvalid[n] && rready[n])) begin
      rready[n] <= ready_draw();
      @(posedge clk_noc);
    end
    d = rdata[n];
    rready[n] <= 1'b0;
  endtask

  task automatic send_words(input int n, input int words);
    for (int j = 0; j < words; j++)
      axi_write(n, axi_addr_t'({dest_tbl[n][j], 2'b00}), data_tbl[n][j], 4'hf);
  endtask

  // Status first, then a data read only when the FIFO holds a word
  task automatic drain_words(input int n, input int words);
    axi_data_t d;
    int        got;
    got = 0;
    while (got < words) begin
      axi_read(n, ADDR_RX_STATUS, d);
      if (d[10:8] != 3'd0) begin
        axi_read(n, ADDR_RX_DATA, d);
        got++;
      end
    end
  endtask

  task automatic run_traffic(input int words, input int to_node, input bit bp_check);
    int       rcv [NOC_SIZE];
    node_id_t rot;
    for (int n = 0; n < NOC_SIZE; n++) rcv[n] = 0;
    for (int n = 0; n < NOC_SIZE; n++) begin
      // Each node reaches every destination from a random start
      rot = node_id_t'($random(seed));
      for (int j = 0; j < words; j++) begin
        dest_tbl[n][j] = (to_node < 0) ? node_id_t'(j + int'(rot)) : node_id_t'(to_node);
        data_tbl[n][j] = $random(seed);
        rcv[dest_tbl[n][j]]++;
      end
    end
    b_done = 0;
    for (int n = 0; n < NOC_SIZE; n++) begin
      automatic int nn = n;
      fork
        send_words(nn, words);
      join_none
    end
    if (bp_check) begin
      repeat (100) @(posedge clk_noc);
      if (b_done > RX_FIFO_DEPTH_DEFAULT) begin
        $display("Back-pressure: %0d writes completed before any read, at most %0d allowed",
                 b_done, RX_FIFO_DEPTH_DEFAULT);
        tb_errors++;
      end
    end
    for (int n = 0; n < NOC_SIZE; n++) begin
      automatic int nn = n;
      fork
        drain_words(nn, rcv[nn]);
      join_none
    end
    wait fork;
  endtask

  task automatic error_responses();
    axi_data_t d;
    for (int n = 0; n < NOC_SIZE; n++) begin
      axi_write(n, 8'h10 + (axi_addr_t'($random(seed)) & 8'hec), $random(seed), 4'hf);
      axi_write(n, axi_addr_t'(n << 2), $random(seed), axi_strb_t'($random(seed)) & 4'h7);
      axi_read(n, ADDR_RX_DATA, d);
      axi_read(n, 8'h18 | (axi_addr_t'($random(seed)) & 8'he4), d);
    end
    // Counts must still match the model
    for (int n = 0; n < NOC_SIZE; n++) axi_read(n, ADDR_RX_STATUS, d);
  endtask

  task automatic finish_test(input string name);
    int errs;
    repeat (2) @(posedge clk_noc);
    if (chk_pending != 0) begin
      $display("Test %s left %0d words undelivered", name, chk_pending);
      tb_errors++;
    end
    errs = chk_errors + tb_errors - err_base;
    err_base = chk_errors + tb_errors;
    if (errs == 0) tests_passed++;
    else tests_failed++;
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
  endtask

  initial begin
    axi_data_t d;
    stall        = 1'b0;
    tb_errors    = 0;
    err_base     = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset        = 1'b1;
    for (int n = 0; n < NOC_SIZE; n++) begin
      awaddr[n]  = '0;
      awvalid[n] = 1'b0;
      wdata[n]   = '0;
      wstrb[n]   = '0;
      wvalid[n]  = 1'b0;
      bready[n]  = 1'b0;
      araddr[n]  = '0;
      arvalid[n] = 1'b0;
      rready[n]  = 1'b0;
    end
    repeat (3) @(posedge clk_noc);
    reset <= 1'b0;

    for (int n = 0; n < NOC_SIZE; n++) axi_read(n, ADDR_RX_STATUS, d);
    finish_test("reset state");
    run_traffic(P2P_WORDS, -1, 1'b0);
    finish_test("point-to-point delivery");
    error_responses();
    finish_test("error responses");
    run_traffic(BP_WORDS, 0, 1'b1);
    finish_test("back-pressure");
    stall = 1'b1;
    run_traffic(SAT_WORDS, NOC_SIZE - 1, 1'b0);
    stall = 1'b0;
    finish_test("contention with stalls");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, chk_errors + tb_errors);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
design/noc_pkg.sv
design/flit_if.sv
design/axi_lite_ni.sv
design/noc_arbiter.sv
design/noc_crossbar.sv
design/rx_fifo.sv
design/ravenoc_lite.sv
test/noc_checker.sv
test/tb_ravenoc_lite.sv

/* Bender.yml */
package:
  name: ravenoc_lite

sources:
  - design/noc_pkg.sv
  - design/flit_if.sv
  - design/axi_lite_ni.sv
  - design/noc_arbiter.sv
  - design/noc_crossbar.sv
  - design/rx_fifo.sv
  - design/ravenoc_lite.sv
  - target: simulation
    files:
      - test/noc_checker.sv
      - test/tb_ravenoc_lite.sv
